// File: vlog.f
nvl_pkg.sv
candidate_fifo.sv
min_cost_tracker.sv
search_fsm.sv
update_emitter.sv
neighbor_locator.sv
tb_graph_model.sv
tb_neighbor_locator.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_neighbor_locator \
	&& ./obj_dir/Vtb_neighbor_locator | tee sim.log \
	|| echo "build or run failed"
grep -q "ALL TESTS PASSED" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tb_neighbor_locator.sv
// Neighbour locator testbench
`timescale 1ns/100ps
`default_nettype none

module tb_neighbor_locator;

	// One scenario row
	typedef struct packed {
		logic [1:0] graph;
		nvl_pkg::approved_set_t set;
		logic [1:0] est;
		logic busy;
		logic [3:0] exp_deact;
		logic [3:0] exp_upd;
	} row_t;

	logic clk;
	logic rst_n;
	logic expand;
	logic approved_ready;
	nvl_pkg::approved_set_t approved_set;
	logic aa_busy = 1'b0;
	nvl_pkg::mem_rd_t relations_rd;
	nvl_pkg::relation_word_t relations_data;
	nvl_pkg::mem_rd_t obstacle_rd;
	logic obstacle_data;
	logic estab_wr_en;
	nvl_pkg::node_addr_t estab_wr_addr;
	nvl_pkg::mem_rd_t estab_rd;
	logic estab_data;
	logic deactivate;
	nvl_pkg::node_addr_t deactivate_addr;
	logic update;
	nvl_pkg::candidate_t update_cand;
	logic done;
	// Model controls
	logic load;
	logic [1:0] graph_sel;
	logic [1:0] est_sel;
	// Busy pattern
	logic busy_mode;
	logic busy_now;
	int seed = 36;
	int rnd;
	// Bookkeeping
	row_t rows [6];
	nvl_pkg::approved_t off_e;
	nvl_pkg::node_addr_t exp_deact [$];
	nvl_pkg::candidate_t exp_upd [$];
	nvl_pkg::node_addr_t got_deact [$];
	nvl_pkg::candidate_t got_upd [$];
	int busy_err = 0;
	int fail_count;
	int tests;
	int tests_failed;
	int wait_limit;
	logic timed_out;

	neighbor_locator DUT (
		.clk(clk), .rst_n(rst_n),
		.expand(expand), .approved_ready(approved_ready), .approved_set(approved_set),
		.aa_busy(aa_busy),
		.relations_rd(relations_rd), .relations_data(relations_data),
		.obstacle_rd(obstacle_rd), .obstacle_data(obstacle_data),
		.estab_wr_en(estab_wr_en), .estab_wr_addr(estab_wr_addr),
		.estab_rd(estab_rd), .estab_data(estab_data),
		.deactivate(deactivate), .deactivate_addr(deactivate_addr),
		.update(update), .update_cand(update_cand), .done(done)
	);

	tb_graph_model GM (
		.clk(clk), .load(load), .graph_sel(graph_sel), .est_sel(est_sel),
		.relations_rd(relations_rd), .relations_data(relations_data),
		.obstacle_rd(obstacle_rd), .obstacle_data(obstacle_data),
		.estab_wr_en(estab_wr_en), .estab_wr_addr(estab_wr_addr),
		.estab_rd(estab_rd), .estab_data(estab_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Random back-pressure with its mode sampled at the edge
	always @(posedge clk) begin
		busy_now = busy_mode;
		#2;
		if (busy_now) begin
			rnd = $random(seed);
			aa_busy = rnd[0];
		end else begin
			aa_busy = 1'b0;
		end
	end

	// Pulse capture at the falling edge
	always @(negedge clk) begin
		if (deactivate) begin
			got_deact.push_back(deactivate_addr);
		end
		if (update) begin
			got_upd.push_back(update_cand);
			if (aa_busy) begin
				busy_err++;
			end
		end
	end

	function automatic nvl_pkg::approved_t approve(input nvl_pkg::node_addr_t addr,
		input nvl_pkg::dist_t path_dist);
		nvl_pkg::approved_t e;
		e.approved = 1'b1;
		e.addr = addr;
		e.distance = path_dist;
		return e;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("[FAIL] %0t %s: got %0h expected %0h", $time, msg, got, exp);
			fail_count++;
		end
	endtask

	task automatic report_test(input string name, input int fails_before);
		tests++;
		if (fail_count != fails_before) begin
			tests_failed++;
		end
		$display("test %0d %s: %s", tests, name,
			(fail_count == fails_before) ? "ok" : "mismatch");
	endtask

	// ******************************
	// Expected pulses from the rules
	// ******************************
	task automatic compute_expected(input nvl_pkg::approved_set_t set);
		nvl_pkg::approved_t ap;
		nvl_pkg::relation_word_t nw;
		nvl_pkg::relation_word_t sw;
		nvl_pkg::relation_t nb;
		nvl_pkg::relation_t sb;
		nvl_pkg::candidate_t c;
		nvl_pkg::cost_t best;
		logic found;
		logic estab [256];
		exp_deact.delete();
		exp_upd.delete();
		for (int a = 0; a < 256; a++) begin
			estab[a] = GM.est_mem[a];
		end
		// Every approved node is established before the drain
		for (int s = 0; s < nvl_pkg::NUM_APPROVED; s++) begin
			if (set[s].approved) begin
				exp_deact.push_back(set[s].addr);
				estab[set[s].addr] = 1'b1;
			end
		end
		for (int s = 0; s < nvl_pkg::NUM_APPROVED; s++) begin
			ap = set[s];
			nw = GM.rel_mem[ap.addr];
			for (int k = 0; k < nvl_pkg::MAX_NEIGHBORS; k++) begin
				nb = nw[k];
				if (!ap.approved || nb.addr == nvl_pkg::NO_LINK || GM.obs_mem[nb.addr]) begin
					continue;
				end
				sw = GM.rel_mem[nb.addr];
				found = 1'b0;
				best = '0;
				// True minimum that keeps the first of equal costs
				for (int j = 0; j < nvl_pkg::MAX_NEIGHBORS; j++) begin
					sb = sw[j];
					if (sb.addr != nvl_pkg::NO_LINK && sb.addr != ap.addr &&
						!GM.obs_mem[sb.addr] && (!found || sb.cost < best)) begin
						found = 1'b1;
						best = sb.cost;
					end
				end
				if (found && !estab[nb.addr]) begin
					c.addr = nb.addr;
					c.sub_cost = best;
					c.parent = ap.addr;
					c.distance = ap.distance + nvl_pkg::dist_t'(nb.cost);
					exp_upd.push_back(c);
				end
			end
		end
	endtask

	// Strobes quiet after reset and expand without ready ignored
	task automatic idle_checks();
		int fails_before;
		fails_before = fail_count;
		@(negedge clk);
		check_value(32'(deactivate), 0, "deactivate after reset");
		check_value(32'(update), 0, "update after reset");
		check_value(32'(done), 0, "done after reset");
		check_value(32'(relations_rd.en), 0, "relations read after reset");
		check_value(32'(obstacle_rd.en), 0, "obstacle read after reset");
		check_value(32'(estab_rd.en), 0, "established read after reset");
		check_value(32'(estab_wr_en), 0, "established write after reset");
		@(posedge clk);
		#2;
		approved_set = {off_e, off_e, off_e, approve(8'h10, 5'd4)};
		expand = 1'b1;
		@(posedge clk);
		#2;
		expand = 1'b0;
		repeat (20) begin
			@(negedge clk);
			check_value(32'(deactivate | done | relations_rd.en), 0, "activity after ignored expand");
		end
		report_test("reset and ignored expand", fails_before);
	endtask

	// ******************************
	// One scenario row
	// ******************************
	task automatic run_row(input int r);
		int fails_before;
		int d_base;
		int u_base;
		int b_base;
		int n;
		fails_before = fail_count;
		@(posedge clk);
		#2;
		graph_sel = rows[r].graph;
		est_sel = rows[r].est;
		approved_set = rows[r].set;
		busy_mode = rows[r].busy;
		load = 1'b1;
		@(posedge clk);
		#2;
		load = 1'b0;
		compute_expected(rows[r].set);
		check_value(exp_deact.size(), 32'(rows[r].exp_deact), "reference deactivate count");
		check_value(exp_upd.size(), 32'(rows[r].exp_upd), "reference update count");
		d_base = got_deact.size();
		u_base = got_upd.size();
		b_base = busy_err;
		expand = 1'b1;
		approved_ready = 1'b1;
		@(posedge clk);
		#2;
		expand = 1'b0;
		n = 0;
		while (n < wait_limit) begin
			@(negedge clk);
			if (done) begin
				break;
			end
			n++;
		end
		if (n >= wait_limit) begin
			$display("Timeout in row %0d, done never arrived", r);
			timed_out = 1'b1;
			fail_count++;
		end else begin
			check_value(got_deact.size() - d_base, exp_deact.size(), "deactivate count");
			check_value(got_upd.size() - u_base, exp_upd.size(), "update count");
			check_value(busy_err - b_base, 0, "updates while aa_busy high");
			for (int i = 0; i < exp_deact.size() && d_base + i < got_deact.size(); i++) begin
				check_value(32'(got_deact[d_base + i]), 32'(exp_deact[i]),
					$sformatf("deactivate %0d", i));
			end
			for (int i = 0; i < exp_upd.size() && u_base + i < got_upd.size(); i++) begin
				check_value(32'(got_upd[u_base + i]), 32'(exp_upd[i]), $sformatf("update %0d", i));
			end
		end
		approved_ready = 1'b0;
		busy_mode = 1'b0;
		report_test($sformatf("row %0d, %0d deactivates, %0d updates", r, exp_deact.size(),
			exp_upd.size()), fails_before);
	endtask

	initial begin
		rst_n = 1'b0;
		expand = 1'b0;
		approved_ready = 1'b0;
		approved_set = '0;
		load = 1'b0;
		graph_sel = 2'd0;
		est_sel = 2'd0;
		busy_mode = 1'b0;
		off_e = '0;
		fail_count = 0;
		tests = 0;
		tests_failed = 0;
		wait_limit = 2000;
		timed_out = 1'b0;
		// Graph, approved slots 3 down to 0, established preset, busy, deactivates, updates
		rows[0] = '{2'd0, {off_e, off_e, off_e, off_e}, 2'd0, 1'b0, 4'd0, 4'd0};
		rows[1] = '{2'd0, {off_e, off_e, off_e, approve(8'h10, 5'd4)}, 2'd0, 1'b0, 4'd1, 4'd2};
		rows[2] = '{2'd0, {approve(8'h10, 5'd4), off_e, approve(8'h11, 5'd10), off_e}, 2'd0,
			1'b0, 4'd2, 4'd3};
		// Earlier approved node and preset entry both dropped
		rows[3] = '{2'd0, {off_e, off_e, approve(8'h20, 5'd7), approve(8'h10, 5'd4)}, 2'd1,
			1'b0, 4'd2, 4'd1};
		rows[4] = '{2'd0, {approve(8'h10, 5'd4), off_e, approve(8'h11, 5'd10), off_e}, 2'd0,
			1'b1, 4'd2, 4'd3};
		rows[5] = '{2'd1, {approve(8'h30, 5'd2), approve(8'h23, 5'd1), approve(8'h11, 5'd10),
			approve(8'h10, 5'd4)}, 2'd0, 1'b1, 4'd4, 4'd3};
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		idle_checks();
		for (int r = 0; r < 6 && !timed_out; r++) begin
			run_row(r);
		end
		$display("tests %0d, failed %0d, mismatches %0d", tests, tests_failed, fail_count);
		if (fail_count == 0 && !timed_out) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_graph_model.sv
// Graph memory model
`timescale 1ns/100ps
`default_nettype none

module tb_graph_model (
	input wire logic clk,
	input wire logic load,
	input wire logic [1:0] graph_sel,
	input wire logic [1:0] est_sel,
	input wire nvl_pkg::mem_rd_t relations_rd,
	output nvl_pkg::relation_word_t relations_data,
	input wire nvl_pkg::mem_rd_t obstacle_rd,
	output logic obstacle_data,
	input wire logic estab_wr_en,
	input wire nvl_pkg::node_addr_t estab_wr_addr,
	input wire nvl_pkg::mem_rd_t estab_rd,
	output logic estab_data
);

	// Relation, obstacle and established memories
	nvl_pkg::relation_word_t rel_mem [256];
	logic obs_mem [256];
	logic est_mem [256];

	function automatic nvl_pkg::relation_t link(input nvl_pkg::node_addr_t addr, input int cost);
		nvl_pkg::relation_t r;
		r.addr = addr;
		r.cost = nvl_pkg::cost_t'(cost);
		return r;
	endfunction

	// ******************************
	// Graph presets
	// ******************************
	task automatic fill(input logic [1:0] g, input logic [1:0] e);
		// Empty relations everywhere, cost tied to the whole address
		for (int a = 0; a < 256; a++) begin
			for (int k = 0; k < nvl_pkg::MAX_NEIGHBORS; k++) begin
				rel_mem[a][k] = link(nvl_pkg::NO_LINK, a ^ (a >> 4) ^ k);
			end
			obs_mem[a] = 1'b0;
			// Preset 1 has one node already established
			est_mem[a] = (e == 2'd1) && (a == 32'h22);
		end
		// Relations listed from slot 3 down to slot 0
		rel_mem[8'h10] = {link(8'h22, 5), link(8'h21, 2), link(nvl_pkg::NO_LINK, 0), link(8'h20, 3)};
		rel_mem[8'h11] = {link(nvl_pkg::NO_LINK, 0), link(nvl_pkg::NO_LINK, 0), link(8'h20, 1),
			link(8'h23, 2)};
		rel_mem[8'h20] = {link(8'h31, 2), link(8'h34, 1), link(8'h30, 4), link(8'h10, 0)};
		// Equal costs in slots 0 and 1
		rel_mem[8'h22] = {link(nvl_pkg::NO_LINK, 0), link(8'h10, 1), link(8'h33, 6), link(8'h32, 6)};
		rel_mem[8'h23] = {link(nvl_pkg::NO_LINK, 0), link(nvl_pkg::NO_LINK, 0), link(8'h21, 1),
			link(8'h11, 3)};
		rel_mem[8'h30] = {link(nvl_pkg::NO_LINK, 0), link(nvl_pkg::NO_LINK, 0), link(8'h31, 9),
			link(8'h20, 7)};
		obs_mem[8'h34] = 1'b1;
		// Graph 1 moves the obstacle from 0x21 to 0x22
		if (g == 2'd0) begin
			obs_mem[8'h21] = 1'b1;
		end else begin
			obs_mem[8'h22] = 1'b1;
		end
	endtask

	// ******************************
	// Ports, one-cycle reads
	// ******************************
	always @(posedge clk) begin
		if (load) begin
			fill(graph_sel, est_sel);
			relations_data <= '0;
			obstacle_data <= 1'b0;
			estab_data <= 1'b0;
		end else begin
			if (relations_rd.en) begin
				relations_data <= rel_mem[relations_rd.addr];
			end
			if (obstacle_rd.en) begin
				obstacle_data <= obs_mem[obstacle_rd.addr];
			end
			if (estab_rd.en) begin
				estab_data <= est_mem[estab_rd.addr];
			end
			// Write lands at the edge
			if (estab_wr_en) begin
				est_mem[estab_wr_addr] = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: neighbor_locator.sv
// Valid neighbour locator top
`timescale 1ns/100ps
`default_nettype none

module neighbor_locator (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic expand,
	input wire logic approved_ready,
	input wire nvl_pkg::approved_set_t approved_set,
	input wire logic aa_busy,
	// Relation and obstacle memories
	output nvl_pkg::mem_rd_t relations_rd,
	input wire nvl_pkg::relation_word_t relations_data,
	output nvl_pkg::mem_rd_t obstacle_rd,
	input wire logic obstacle_data,
	// Established memory
	output logic estab_wr_en,
	output nvl_pkg::node_addr_t estab_wr_addr,
	output nvl_pkg::mem_rd_t estab_rd,
	input wire logic estab_data,
	// Active-node tracker side
	output logic deactivate,
	output nvl_pkg::node_addr_t deactivate_addr,
	output logic update,
	output nvl_pkg::candidate_t update_cand,
	output logic done
);

	// Controller to tracker
	logic sub_clear;
	logic sub_offer;
	nvl_pkg::cost_t offer_cost;
	logic best_valid;
	nvl_pkg::cost_t best_cost;
	// Queue
	logic push;
	nvl_pkg::candidate_t push_cand;
	logic pop;
	nvl_pkg::candidate_t head;
	logic empty;
	// Drain handover
	logic drain_en;
	logic drained;

	search_fsm u_search_fsm (
		.clk(clk), .rst_n(rst_n),
		.expand(expand), .approved_ready(approved_ready), .approved_set(approved_set),
		.relations_rd(relations_rd), .relations_data(relations_data),
		.obstacle_rd(obstacle_rd), .obstacle_data(obstacle_data),
		.estab_wr_en(estab_wr_en), .estab_wr_addr(estab_wr_addr),
		.deactivate(deactivate), .deactivate_addr(deactivate_addr),
		.sub_clear(sub_clear), .sub_offer(sub_offer), .offer_cost(offer_cost),
		.best_valid(best_valid), .best_cost(best_cost),
		.push(push), .push_cand(push_cand),
		.drain_en(drain_en), .drained(drained), .done(done)
	);

	min_cost_tracker u_min_cost_tracker (
		.clk(clk), .rst_n(rst_n),
		.sub_clear(sub_clear), .sub_offer(sub_offer), .offer_cost(offer_cost),
		.best_valid(best_valid), .best_cost(best_cost)
	);

	// Full stays internal, guarded by the queue itself
	candidate_fifo #(
		.payload_t(nvl_pkg::candidate_t),
		.DEPTH(nvl_pkg::FIFO_DEPTH)
	) u_candidate_fifo (
		.clk(clk), .rst_n(rst_n),
		.push(push), .push_data(push_cand),
		.pop(pop), .head(head), .empty(empty), .full()
	);

	update_emitter u_update_emitter (
		.clk(clk), .rst_n(rst_n),
		.drain_en(drain_en), .aa_busy(aa_busy),
		.empty(empty), .head(head), .pop(pop),
		.estab_rd(estab_rd), .estab_data(estab_data),
		.update(update), .update_cand(update_cand), .drained(drained)
	);

endmodule

`default_nettype wire

// File: update_emitter.sv
// Candidate drain and update emitter
`timescale 1ns/100ps
`default_nettype none

module update_emitter (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic drain_en,
	input wire logic aa_busy,
	input wire logic empty,
	input wire nvl_pkg::candidate_t head,
	output logic pop,
	output nvl_pkg::mem_rd_t estab_rd,
	input wire logic estab_data,
	output logic update,
	output nvl_pkg::candidate_t update_cand,
	output logic drained
);

	// Established check waiting for its read data
	logic in_flight;
	logic check_issue;

	// ******************************
	// Check issue
	// ******************************
	// One head at a time, never while the tracker is busy
	assign check_issue = drain_en && !empty && !aa_busy && !in_flight;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_flight <= 1'b0;
		end else begin
			in_flight <= check_issue;
		end
	end

	assign estab_rd.en = check_issue;
	assign estab_rd.addr = head.addr;

	// ******************************
	// Second cycle, pop and update
	// ******************************
	// Busy in the data cycle drops the check, head stays and is read again
	assign pop = in_flight && !aa_busy;

	// Already established neighbours are popped silently
	assign update = pop && !estab_data;

	// Head is still the checked entry until the pop takes effect
	assign update_cand = head;

	// Nothing queued and nothing pending
	assign drained = empty && !in_flight;

	// Every update follows a read of the same neighbour
	a_update_checked: assert property (@(posedge clk) disable iff (!rst_n)
		update |-> $past(estab_rd.en) && ($past(estab_rd.addr) == update_cand.addr));

endmodule

`default_nettype wire

// File: search_fsm.sv
// Approved node scan controller
`timescale 1ns/100ps
`default_nettype none

module search_fsm (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic expand,
	input wire logic approved_ready,
	input wire nvl_pkg::approved_set_t approved_set,
	output nvl_pkg::mem_rd_t relations_rd,
	input wire nvl_pkg::relation_word_t relations_data,
	output nvl_pkg::mem_rd_t obstacle_rd,
	input wire logic obstacle_data,
	output logic estab_wr_en,
	output nvl_pkg::node_addr_t estab_wr_addr,
	output logic deactivate,
	output nvl_pkg::node_addr_t deactivate_addr,
	output logic sub_clear,
	output logic sub_offer,
	output nvl_pkg::cost_t offer_cost,
	input wire logic best_valid,
	input wire nvl_pkg::cost_t best_cost,
	output logic push,
	output nvl_pkg::candidate_t push_cand,
	output logic drain_en,
	input wire logic drained,
	output logic done
);

	nvl_pkg::fsm_state_t state;
	nvl_pkg::fsm_state_t next_state;
	nvl_pkg::fsm_state_t after_nbr;
	// Slot, neighbour and sub-neighbour counters
	nvl_pkg::slot_t slot;
	nvl_pkg::nbr_t nbr;
	nvl_pkg::nbr_t sub;
	// Relations of the approved node and of the current neighbour
	nvl_pkg::relation_word_t node_word;
	nvl_pkg::relation_word_t sub_word;
	nvl_pkg::approved_t cur;
	nvl_pkg::relation_t cur_nbr;
	nvl_pkg::relation_t cur_sub;
	logic nbr_link;
	logic sub_link;
	logic nbr_skip;
	logic last_slot;
	logic last_nbr;
	logic last_sub;

	assign cur = approved_set[slot];
	assign cur_nbr = node_word[nbr];
	assign cur_sub = sub_word[sub];
	assign nbr_link = (cur_nbr.addr != nvl_pkg::NO_LINK);
	assign sub_link = (cur_sub.addr != nvl_pkg::NO_LINK);
	// Obstacle bit belongs to the neighbour read in the cycle before
	assign nbr_skip = !nbr_link || obstacle_data;
	assign last_slot = (slot == nvl_pkg::slot_t'(nvl_pkg::NUM_APPROVED - 1));
	assign last_nbr = (nbr == nvl_pkg::nbr_t'(nvl_pkg::MAX_NEIGHBORS - 1));
	assign last_sub = (sub == nvl_pkg::nbr_t'(nvl_pkg::MAX_NEIGHBORS - 1));

	// ******************************
	// State sequencing
	// ******************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= nvl_pkg::ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		// Where to go once a neighbour is finished
		if (!last_nbr) begin
			after_nbr = nvl_pkg::ST_NBR_RD;
		end else if (!last_slot) begin
			after_nbr = nvl_pkg::ST_SLOT;
		end else begin
			after_nbr = nvl_pkg::ST_DRAIN;
		end
		next_state = state;
		case (state)
			nvl_pkg::ST_IDLE: begin
				if (expand && approved_ready) begin
					next_state = nvl_pkg::ST_SLOT;
				end
			end
			nvl_pkg::ST_SLOT: begin
				if (cur.approved) begin
					next_state = nvl_pkg::ST_NODE_RD;
				end else if (last_slot) begin
					next_state = nvl_pkg::ST_DRAIN;
				end
			end
			nvl_pkg::ST_NODE_RD: next_state = nvl_pkg::ST_NODE_LATCH;
			nvl_pkg::ST_NODE_LATCH: next_state = nvl_pkg::ST_NBR_RD;
			nvl_pkg::ST_NBR_RD: next_state = nvl_pkg::ST_NBR_EVAL;
			nvl_pkg::ST_NBR_EVAL: next_state = nbr_skip ? after_nbr : nvl_pkg::ST_SUB_RD;
			nvl_pkg::ST_SUB_RD: next_state = nvl_pkg::ST_SUB_EVAL;
			nvl_pkg::ST_SUB_EVAL: next_state = last_sub ? nvl_pkg::ST_PUSH : nvl_pkg::ST_SUB_RD;
			nvl_pkg::ST_PUSH: next_state = after_nbr;
			nvl_pkg::ST_DRAIN: begin
				if (drained) begin
					next_state = nvl_pkg::ST_IDLE;
				end
			end
			default: next_state = nvl_pkg::ST_IDLE;
		endcase
	end

	// ******************************
	// Counters
	// ******************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot <= '0;
			nbr <= '0;
			sub <= '0;
		end else begin
			case (state)
				nvl_pkg::ST_IDLE: slot <= '0;
				// Skipped slot moves on at once
				nvl_pkg::ST_SLOT: begin
					if (!cur.approved) begin
						slot <= slot + 1'b1;
					end
				end
				nvl_pkg::ST_NODE_RD: nbr <= '0;
				nvl_pkg::ST_NBR_EVAL: begin
					sub <= '0;
					if (nbr_skip) begin
						nbr <= nbr + 1'b1;
						if (last_nbr) begin
							slot <= slot + 1'b1;
						end
					end
				end
				nvl_pkg::ST_SUB_EVAL: sub <= sub + 1'b1;
				nvl_pkg::ST_PUSH: begin
					nbr <= nbr + 1'b1;
					if (last_nbr) begin
						slot <= slot + 1'b1;
					end
				end
				default: begin
					slot <= slot;
				end
			endcase
		end
	end

	// Relation words arrive one cycle after their read
	always_ff @(posedge clk) begin
		if (state == nvl_pkg::ST_NODE_LATCH) begin
			node_word <= relations_data;
		end
		if (state == nvl_pkg::ST_NBR_EVAL && !nbr_skip) begin
			sub_word <= relations_data;
		end
	end

	// ******************************
	// Memory requests
	// ******************************
	// Empty relations issue no read
	assign relations_rd.en = (state == nvl_pkg::ST_NODE_RD) ||
		(state == nvl_pkg::ST_NBR_RD && nbr_link);
	assign relations_rd.addr = (state == nvl_pkg::ST_NODE_RD) ? cur.addr : cur_nbr.addr;
	assign obstacle_rd.en = (state == nvl_pkg::ST_NBR_RD && nbr_link) ||
		(state == nvl_pkg::ST_SUB_RD && sub_link);
	assign obstacle_rd.addr = (state == nvl_pkg::ST_SUB_RD) ? cur_sub.addr : cur_nbr.addr;

	// Approved node becomes established as it is deactivated
	assign estab_wr_en = (state == nvl_pkg::ST_NODE_RD);
	assign estab_wr_addr = cur.addr;
	assign deactivate = (state == nvl_pkg::ST_NODE_RD);
	assign deactivate_addr = cur.addr;

	// The approved node itself never counts in the sub-scan
	assign sub_clear = (state == nvl_pkg::ST_NBR_EVAL) && !nbr_skip;
	assign sub_offer = (state == nvl_pkg::ST_SUB_EVAL) && sub_link &&
		(cur_sub.addr != cur.addr) && !obstacle_data;
	assign offer_cost = cur_sub.cost;

	// Candidate only when some sub-neighbour qualified
	assign push = (state == nvl_pkg::ST_PUSH) && best_valid;
	assign push_cand.addr = cur_nbr.addr;
	assign push_cand.sub_cost = best_cost;
	assign push_cand.parent = cur.addr;
	assign push_cand.distance = cur.distance + nvl_pkg::dist_t'(cur_nbr.cost);

	assign drain_en = (state == nvl_pkg::ST_DRAIN);
	assign done = (state == nvl_pkg::ST_DRAIN) && drained;

	// Approved set is held steady for the whole run
	a_set_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(state != nvl_pkg::ST_IDLE) |-> $stable(approved_set));
	// An approved node never sits at the empty-relation address
	a_node_addr: assert property (@(posedge clk) disable iff (!rst_n)
		deactivate |-> (deactivate_addr != nvl_pkg::NO_LINK));

endmodule

`default_nettype wire

// File: min_cost_tracker.sv
// Cheapest sub-neighbour tracker
`timescale 1ns/100ps
`default_nettype none

module min_cost_tracker (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic sub_clear,
	input wire logic sub_offer,
	input wire nvl_pkg::cost_t offer_cost,
	output logic best_valid,
	output nvl_pkg::cost_t best_cost
);

	logic take;

	// Strictly lower wins, a tie keeps the earlier entry
	assign take = sub_offer && (!best_valid || (offer_cost < best_cost));

	// Found flag, cleared at the start of each sub-scan
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			best_valid <= 1'b0;
		end else if (sub_clear) begin
			best_valid <= 1'b0;
		end else if (take) begin
			best_valid <= 1'b1;
		end
	end

	// Stored cost, meaningful only with best_valid
	always_ff @(posedge clk) begin
		if (take) begin
			best_cost <= offer_cost;
		end
	end

	// Controller never clears in the middle of an offer
	a_clear_offer: assert property (@(posedge clk) disable iff (!rst_n)
		!(sub_clear && sub_offer));

endmodule

`default_nettype wire

// File: candidate_fifo.sv
// Candidate queue
`timescale 1ns/100ps
`default_nettype none

module candidate_fifo #(
	parameter type payload_t = nvl_pkg::candidate_t,
	parameter int DEPTH = nvl_pkg::FIFO_DEPTH
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic push,
	input wire payload_t push_data,
	input wire logic pop,
	output payload_t head,
	output logic empty,
	output logic full
);

	typedef logic [$clog2(DEPTH)-1:0] ptr_t;
	typedef logic [$clog2(DEPTH):0] cnt_t;

	// Storage, no reset on payload
	payload_t mem [DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count;

	// Circular pointer advance
	function automatic ptr_t next_ptr(input ptr_t p);
		return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// ******************************
	// Pointers and occupancy
	// ******************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// Push and pop together leave the count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head shows the next entry one cycle after a pop
	assign head = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == cnt_t'(DEPTH));

	// Producer must respect full, consumer must respect empty
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

`default_nettype wire

// File: nvl_pkg.sv
// Neighbour locator definitions
`default_nettype none

package nvl_pkg;

	// ******************************
	// Widths and sizes
	// ******************************

	// Node address width
	localparam int ADDR_W = 8;
	// Edge cost width
	localparam int COST_W = 4;
	// Path distance width
	localparam int DIST_W = 5;
	// Relations held per node
	localparam int MAX_NEIGHBORS = 4;
	// Candidate slots from the approved-node set
	localparam int NUM_APPROVED = 4;
	// Every approved node times every neighbour
	localparam int FIFO_DEPTH = NUM_APPROVED * MAX_NEIGHBORS;
	// Counter widths for the scan
	localparam int SLOT_W = $clog2(NUM_APPROVED);
	localparam int NBR_W = $clog2(MAX_NEIGHBORS);

	// ******************************
	// Scalar types
	// ******************************

	typedef logic [ADDR_W-1:0] node_addr_t;
	typedef logic [COST_W-1:0] cost_t;
	typedef logic [DIST_W-1:0] dist_t;
	typedef logic [SLOT_W-1:0] slot_t;
	typedef logic [NBR_W-1:0] nbr_t;

	// All-ones address marks an empty relation
	localparam node_addr_t NO_LINK = '1;

	// ******************************
	// Structured types
	// ******************************

	// One 12-bit relation
	typedef struct packed {
		node_addr_t addr;
		cost_t cost;
	} relation_t;

	// 48-bit relation memory word
	typedef relation_t [MAX_NEIGHBORS-1:0] relation_word_t;

	// One 14-bit approved-set entry
	typedef struct packed {
		logic approved;
		node_addr_t addr;
		dist_t distance;
	} approved_t;

	typedef approved_t [NUM_APPROVED-1:0] approved_set_t;

	// 25-bit queued candidate and update payload
	typedef struct packed {
		node_addr_t addr;
		cost_t sub_cost;
		node_addr_t parent;
		dist_t distance;
	} candidate_t;

	// 9-bit memory read port request
	typedef struct packed {
		logic en;
		node_addr_t addr;
	} mem_rd_t;

	// Controller states
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_SLOT,
		ST_NODE_RD,
		ST_NODE_LATCH,
		ST_NBR_RD,
		ST_NBR_EVAL,
		ST_SUB_RD,
		ST_SUB_EVAL,
		ST_PUSH,
		ST_DRAIN
	} fsm_state_t;

endpackage

`default_nettype wire
